// ==== vlog.f ====
source/act_pkg.sv
source/unpacked_fifo.sv
source/roller.sv
source/logsigmoid_lut.sv
source/fixed_logsigmoid.sv
tests/tb_fixed_logsigmoid.sv

// ==== Makefile ====
# Verilator flow for the log-sigmoid activation unit
# run from the project root so the table file path resolves

VERILATOR ?= verilator
TOP       ?= tb_fixed_logsigmoid
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
SEED      ?= 1
TRACE     ?= 0
VFLAGS    ?= --assert --timing -x-assign unique -x-initial unique
RUNFLAGS  ?= +verilator+seed+$(SEED) +verilator+rand+reset+2

ifeq ($(TRACE),1)
TRACE_FLAGS := --trace
else
TRACE_FLAGS :=
endif

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(TRACE_FLAGS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) $(RUNFLAGS)

clean:
	rm -rf $(OBJ_DIR)

// ==== source/logsigmoid_map.mem ====
// one 6-bit two's complement log-sigmoid value per line, line c holds input code c
111010
111011
111011
111100
111100
111101
111101
111101
111101
111110
111110
111110
111110
111111
111111
111111
111111
111111
111111
111111
111111
111111
000000
000000
000000
000000
000000
000000
000000
000000
000000
000000
100000
100001
100010
100011
100100
100101
100110
100111
101000
101001
101010
101010
101011
101100
101101
101110
101111
110000
110001
110010
110010
110011
110100
110101
110101
110110
110111
111000
111000
111001
111001
111010

// ==== tests/tb_fixed_logsigmoid.sv ====
`timescale 1ns/100ps

module tb_fixed_logsigmoid
  import act_pkg::*;
();

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 16;
  localparam int SWEEP_BEATS     = LUT_SIZE / IN_LANES;
  localparam int RANDOM_BEATS    = 300;
  localparam int TOTAL_BEATS     = SWEEP_BEATS + RANDOM_BEATS + FIFO_DEPTH;
  // worst-case stall factor per chunk
  localparam int STALL_FACTOR    = 8;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * ROLL_RATIO * STALL_FACTOR + RESET_CYCLES;
  // longest wait for the pipeline to empty
  localparam int DRAIN_CYCLES    = (FIFO_DEPTH + 2) * ROLL_RATIO * STALL_FACTOR;
  localparam int CHUNK_W         = OUT_LANES * DATA_WIDTH;
  localparam int BEAT_W          = IN_LANES * DATA_WIDTH;

  logic                  clk;
  logic                  arst_n;
  logic [DATA_WIDTH-1:0] data_in [IN_LANES-1:0];
  logic                  data_in_valid;
  logic                  data_in_ready;
  logic [DATA_WIDTH-1:0] data_out [OUT_LANES-1:0];
  logic                  data_out_valid;
  logic                  data_out_ready;

  integer seed;

  // expected output chunks, oldest first
  logic [CHUNK_W-1:0] exp_q [$];
  // random back-pressure on the output side
  logic               rand_ready_en;

  // snapshot of a stalled output
  logic                  stall_seen;
  logic [DATA_WIDTH-1:0] stall_data [OUT_LANES-1:0];

  fixed_logsigmoid dut0 (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // log-sigmoid of one code, straight from the math
  function automatic logic [DATA_WIDTH-1:0] expected_logsig(input logic [DATA_WIDTH-1:0] code);
    real x;
    real y;
    int  q;
    x = real'($signed(code)) / real'(2 ** FRAC_BITS);
    y = $ln(1.0 / (1.0 + $exp(-x))) * real'(2 ** FRAC_BITS);
    // nearest, halves away from zero
    if (y < 0.0) begin
      q = -int'($floor(-y + 0.5));
    end else begin
      q = int'($floor(y + 0.5));
    end
    // clamp into -32 .. 0
    if (q < -(2 ** (DATA_WIDTH - 1))) begin
      q = -(2 ** (DATA_WIDTH - 1));
    end
    if (q > 0) begin
      q = 0;
    end
    return q[DATA_WIDTH-1:0];
  endfunction

  function automatic logic [BEAT_W-1:0] random_beat();
    logic [BEAT_W-1:0] beat;
    for (int i = 0; i < IN_LANES; i++) begin
      beat[i*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'($random(seed));
    end
    return beat;
  endfunction

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    if (got !== expected) begin
      $display("[FAIL] time %0t: %s is %0d, expected %0d", $time, name,
               $signed(got), $signed(expected));
      abort_run();
    end
  endtask

  // one falling edge, new random ready if enabled
  task automatic next_cycle();
    @(negedge clk);
    if (rand_ready_en) begin
      data_out_ready = (($random(seed) & 3) != 0);
    end
  endtask

  task automatic drive_lanes(input logic [BEAT_W-1:0] beat);
    for (int i = 0; i < IN_LANES; i++) begin
      data_in[i] = beat[i*DATA_WIDTH +: DATA_WIDTH];
    end
  endtask

  // offer one beat and hold it until accepted
  task automatic send_beat(input logic [BEAT_W-1:0] beat);
    logic taken;
    taken = 1'b0;
    drive_lanes(beat);
    data_in_valid = 1'b1;
    while (!taken) begin
      // ready comes from fifo occupancy, steady until the rising edge
      taken = data_in_ready;
      next_cycle();
    end
    data_in_valid = 1'b0;
  endtask

  // wait for the scoreboard to empty, bounded
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_CYCLES) begin
      next_cycle();
      cycles++;
    end
  endtask

  // scoreboard, pop before push within one edge
  always @(posedge clk) begin
    logic [CHUNK_W-1:0] chunk;
    if (arst_n) begin
      if (data_out_valid && data_out_ready) begin
        if (exp_q.size() == 0) begin
          $display("output chunk at time %0t has no input beat left to match it", $time);
          abort_run();
        end else begin
          chunk = exp_q.pop_front();
          for (int i = 0; i < OUT_LANES; i++) begin
            compare_value($sformatf("data_out[%0d]", i), 32'($signed(data_out[i])),
                          32'($signed(chunk[i*DATA_WIDTH +: DATA_WIDTH])));
          end
        end
      end
      // split the accepted beat, lowest lanes first
      if (data_in_valid && data_in_ready) begin
        for (int k = 0; k < ROLL_RATIO; k++) begin
          for (int i = 0; i < OUT_LANES; i++) begin
            chunk[i*DATA_WIDTH +: DATA_WIDTH] = expected_logsig(data_in[k*OUT_LANES + i]);
          end
          exp_q.push_back(chunk);
        end
      end
    end
  end

  // remember a stalled output
  always @(posedge clk) begin
    if (!arst_n) begin
      stall_seen <= 1'b0;
    end else begin
      stall_seen <= data_out_valid && !data_out_ready;
      for (int i = 0; i < OUT_LANES; i++) begin
        stall_data[i] <= data_out[i];
      end
    end
  end

  // and check it held across the edge
  always @(negedge clk) begin
    if (stall_seen) begin
      compare_value("stalled data_out_valid", 32'(data_out_valid), 32'(1'b1));
      for (int i = 0; i < OUT_LANES; i++) begin
        compare_value($sformatf("stalled data_out[%0d]", i), 32'(data_out[i]),
                      32'(stall_data[i]));
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d clock cycles, the pipeline seems hung",
             WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin
    logic [BEAT_W-1:0] beat;
    logic              taken;
    int                accepted;
    int                gap;
    time               sweep_start;
    seed           = 32'h98f7;
    clk            = 1'b0;
    arst_n         = 1'b0;
    data_in_valid  = 1'b0;
    data_out_ready = 1'b1;
    rand_ready_en  = 1'b0;
    sweep_start    = 0;
    for (int i = 0; i < IN_LANES; i++) begin
      data_in[i] = '0;
    end

    // reset state, during and just after
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      compare_value("data_out_valid", 32'(data_out_valid), 32'(1'b0));
      compare_value("data_in_ready", 32'(data_in_ready), 32'(1'b1));
    end
    arst_n = 1'b1;
    next_cycle();
    compare_value("data_out_valid", 32'(data_out_valid), 32'(1'b0));
    compare_value("data_in_ready", 32'(data_in_ready), 32'(1'b1));

    // every code once, in order
    for (int b = 0; b < SWEEP_BEATS; b++) begin
      for (int i = 0; i < IN_LANES; i++) begin
        beat[i*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(b * IN_LANES + i);
      end
      send_beat(beat);
      // first beat taken on the rising edge just passed
      if (b == 0) begin
        sweep_start = $time;
      end
    end
    wait_drained();
    // first chunk two edges after acceptance, then one chunk per cycle
    compare_value("sweep cycles to drain", 32'(($time - sweep_start) / CLK_PERIOD),
                  32'(SWEEP_BEATS * ROLL_RATIO + 1));

    // random codes, input gaps, random ready
    rand_ready_en = 1'b1;
    for (int n = 0; n < RANDOM_BEATS; n++) begin
      gap = $random(seed) & 3;
      repeat (gap) begin
        next_cycle();
      end
      send_beat(random_beat());
    end
    wait_drained();
    rand_ready_en  = 1'b0;
    data_out_ready = 1'b1;
    next_cycle();

    // output blocked, input pushing every cycle
    data_out_ready = 1'b0;
    accepted       = 0;
    drive_lanes(random_beat());
    data_in_valid = 1'b1;
    repeat (FIFO_DEPTH * ROLL_RATIO + 8) begin
      taken = data_in_ready;
      next_cycle();
      if (taken) begin
        accepted++;
        drive_lanes(random_beat());
      end
    end
    data_in_valid = 1'b0;
    compare_value("beats accepted under back-pressure", 32'(accepted), 32'(FIFO_DEPTH));
    compare_value("data_in_ready with a full FIFO", 32'(data_in_ready), 32'(1'b0));
    data_out_ready = 1'b1;
    wait_drained();
    next_cycle();

    if (exp_q.size() != 0) begin
      $display("%0d expected chunks never reached the output", exp_q.size());
      abort_run();
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// ==== source/fixed_logsigmoid.sv ====
`timescale 1ns/100ps

module fixed_logsigmoid
  import act_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [DATA_WIDTH-1:0] data_in [IN_LANES-1:0],
  input  logic                  data_in_valid,
  output logic                  data_in_ready,
  output logic [DATA_WIDTH-1:0] data_out [OUT_LANES-1:0],
  output logic                  data_out_valid,
  input  logic                  data_out_ready
);

  // fifo head towards the roller
  logic [DATA_WIDTH-1:0] fifo_data [IN_LANES-1:0];
  logic                  fifo_valid;
  logic                  fifo_ready;

  // narrow chunks towards the table stage
  logic [DATA_WIDTH-1:0] roll_data [OUT_LANES-1:0];
  logic                  roll_valid;
  logic                  roll_ready;

  // wide beats wait here while chunks go out
  unpacked_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) roller_buffer (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out       (fifo_data),
    .data_out_valid (fifo_valid),
    .data_out_ready (fifo_ready)
  );

  // wide to narrow, lowest lanes first
  roller roller_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (fifo_data),
    .data_in_valid  (fifo_valid),
    .data_in_ready  (fifo_ready),
    .data_out       (roll_data),
    .data_out_valid (roll_valid),
    .data_out_ready (roll_ready)
  );

  // table lookup, one register stage to the outputs
  logsigmoid_lut lut_stage (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (roll_data),
    .data_in_valid  (roll_valid),
    .data_in_ready  (roll_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

endmodule

// ==== source/logsigmoid_lut.sv ====
`timescale 1ns/100ps

module logsigmoid_lut
  import act_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [DATA_WIDTH-1:0] data_in [OUT_LANES-1:0],
  input  logic                  data_in_valid,
  output logic                  data_in_ready,
  output logic [DATA_WIDTH-1:0] data_out [OUT_LANES-1:0],
  output logic                  data_out_valid,
  input  logic                  data_out_ready
);

  // log-sigmoid table, indexed by the raw code
  logic [DATA_WIDTH-1:0] lut_mem [LUT_SIZE];

  logic load;

  initial begin
    $readmemb(LUT_FILE, lut_mem);
  end

  // take a new chunk when empty or draining this cycle
  assign data_in_ready = !data_out_valid || data_out_ready;
  assign load          = data_in_valid && data_in_ready;

  // output valid flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_out_valid <= 1'b0;
    end else if (data_in_ready) begin
      data_out_valid <= data_in_valid;
    end
  end

  // lookup per lane, result held under stall
  always_ff @(posedge clk) begin
    if (load) begin
      for (int i = 0; i < OUT_LANES; i++) begin
        data_out[i] <= lut_mem[data_in[i]];
      end
    end
  end

  // stalled result holds until taken
  for (genvar g = 0; g < OUT_LANES; g++) begin : g_stall_chk
    stall_hold_a : assert property (
      @(posedge clk) disable iff (!arst_n)
      (data_out_valid && !data_out_ready) |=> (data_out_valid && $stable(data_out[g]))
    );
  end

endmodule

// ==== source/roller.sv ====
`timescale 1ns/100ps

module roller
  import act_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [DATA_WIDTH-1:0] data_in [IN_LANES-1:0],
  input  logic                  data_in_valid,
  output logic                  data_in_ready,
  output logic [DATA_WIDTH-1:0] data_out [OUT_LANES-1:0],
  output logic                  data_out_valid,
  input  logic                  data_out_ready
);

  // chunk counter width, at least one bit
  localparam int CNT_W = (ROLL_RATIO > 1) ? $clog2(ROLL_RATIO) : 1;

  // which slice of the head beat is on the output
  logic [CNT_W-1:0] chunk_cnt;

  logic last_chunk;
  logic out_fire;

  assign last_chunk = (chunk_cnt == CNT_W'(ROLL_RATIO - 1));
  assign out_fire   = data_out_valid && data_out_ready;

  // a chunk is on offer whenever the head is
  assign data_out_valid = data_in_valid;

  // release the head only with its final chunk
  assign data_in_ready = data_out_ready && last_chunk;

  // slice select
  // chunk k carries lanes k*OUT_LANES upward
  always_comb begin
    for (int i = 0; i < OUT_LANES; i++) begin
      data_out[i] = data_in[int'(chunk_cnt) * OUT_LANES + i];
    end
  end

  // advance per narrow transfer
  // wrap on the last one, same edge the fifo pops
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      chunk_cnt <= '0;
    end else if (out_fire) begin
      if (last_chunk) begin
        chunk_cnt <= '0;
      end else begin
        chunk_cnt <= chunk_cnt + 1'b1;
      end
    end
  end

  // counter never points past the last slice
  chunk_bound_a : assert property (
    @(posedge clk) disable iff (!arst_n) int'(chunk_cnt) < ROLL_RATIO
  );

  // mid-beat the fifo head must still be there
  // it is only popped on the wrapping transfer
  head_held_a : assert property (
    @(posedge clk) disable iff (!arst_n) (chunk_cnt != '0) |-> data_in_valid
  );

endmodule

// ==== source/unpacked_fifo.sv ====
`timescale 1ns/100ps

module unpacked_fifo
  import act_pkg::*;
#(
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [DATA_WIDTH-1:0] data_in [IN_LANES-1:0],
  input  logic                  data_in_valid,
  output logic                  data_in_ready,
  output logic [DATA_WIDTH-1:0] data_out [IN_LANES-1:0],
  output logic                  data_out_valid,
  input  logic                  data_out_ready
);

  // pointer and occupancy widths
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // storage, one whole lane array per slot
  logic [DATA_WIDTH-1:0] mem [DEPTH-1:0][IN_LANES-1:0];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic push;
  logic pop;

  // handshakes on both sides
  assign push = data_in_valid && data_in_ready;
  assign pop  = data_out_valid && data_out_ready;

  // accept while a slot is free
  assign data_in_ready  = (count != CNT_W'(DEPTH));
  // head is valid whenever something is stored
  assign data_out_valid = (count != '0);

  // head shown without a register, fall-through
  always_comb begin
    for (int i = 0; i < IN_LANES; i++) begin
      data_out[i] = mem[rd_ptr][i];
    end
  end

  // payload write, no reset on storage
  always_ff @(posedge clk) begin
    if (push) begin
      for (int i = 0; i < IN_LANES; i++) begin
        mem[wr_ptr][i] <= data_in[i];
      end
    end
  end

  // write pointer, wraps for any depth
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
    end else if (push) begin
      if (wr_ptr == PTR_W'(DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // read pointer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
    end else if (pop) begin
      if (rd_ptr == PTR_W'(DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // occupancy
  // push and pop together leave it unchanged
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (push && !pop) begin
      count <= count + 1'b1;
    end else if (pop && !push) begin
      count <= count - 1'b1;
    end
  end

  // never more beats than slots
  count_bound_a : assert property (
    @(posedge clk) disable iff (!arst_n) count <= CNT_W'(DEPTH)
  );

  // pointers meet only when empty or full
  ptr_count_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    (wr_ptr == rd_ptr) == ((count == '0) || (count == CNT_W'(DEPTH)))
  );

endmodule

// ==== source/act_pkg.sv ====
package act_pkg;

  // two's complement width of one value, shared by input and output
  localparam int DATA_WIDTH = 6;

  // fraction bits, code c stands for c / 8
  localparam int FRAC_BITS = 3;

  // values per input beat
  localparam int IN_LANES = 4;

  // values per output beat, must divide IN_LANES
  localparam int OUT_LANES = 2;

  // narrow beats produced from one wide beat
  localparam int ROLL_RATIO = IN_LANES / OUT_LANES;

  // wide beats held by the input buffer
  localparam int FIFO_DEPTH = 4;

  // one table entry per input code
  localparam int LUT_SIZE = 2 ** DATA_WIDTH;

  // table contents, one binary entry per line
  // entry c: x = signed(c) / 2**FRAC_BITS
  // y = ln(1 / (1 + exp(-x))) scaled by 2**FRAC_BITS
  // rounded to nearest, ties away from zero
  // saturated to -32 .. 0, stored as 6-bit two's complement
  // path is relative to the project root
  localparam string LUT_FILE = "source/logsigmoid_map.mem";

endpackage
